// ==== rtl/scc_pkg.sv ====
package scc_pkg;

	typedef logic [7:0] reg_byte_t;   // One register value or one bus byte
	typedef logic [3:0] reg_index_t;  // Register pointer, 0 to 15
	typedef logic [1:0] reg_sel_t;    // Bus register select from the address lines
	typedef logic [2:0] vec_stat_t;   // Interrupt status code for the modified vector

	// Register select bits
	localparam int RS_DATA_BIT   = 1;  // Set for the data port, clear for control
	localparam int RS_SIDE_A_BIT = 0;  // Set for channel A, clear for channel B

	// Write register numbers
	localparam reg_index_t WR_IRQ_ENABLE  = 4'd1;   // WR1, interrupt enables
	localparam reg_index_t WR_VECTOR      = 4'd2;   // WR2, shared interrupt vector
	localparam reg_index_t WR_MASTER_CTRL = 4'd9;   // WR9, shared master control
	localparam reg_index_t WR_TIME_LO     = 4'd12;  // WR12, baud time constant low
	localparam reg_index_t WR_TIME_HI     = 4'd13;  // WR13, baud time constant high
	localparam reg_index_t WR_EXT_ENABLE  = 4'd15;  // WR15, ext/status enables

	// Command field of WR0, bits 5:3
	localparam logic [2:0] CMD_POINT_HIGH = 3'b001;  // Adds 8 to the next pointer
	localparam logic [2:0] CMD_RESET_EXT  = 3'b010;  // Reopens the ext/status latch

	// Reset codes in WR9 bits 7:6
	localparam logic [1:0] RST_CHAN_A = 2'b10;  // Channel A reset
	localparam logic [1:0] RST_CHAN_B = 2'b01;  // Channel B reset
	localparam logic [1:0] RST_FULL   = 2'b11;  // Hardware-equivalent full reset

	// Reset and read values
	localparam reg_byte_t WR15_RESET = 8'hF8;  // WR15 after a full reset
	localparam reg_byte_t RR15_MASK  = 8'hFA;  // Bits of WR15 that show in RR15
	localparam reg_byte_t RR0_IDLE   = 8'h44;  // Tx underrun and Tx empty, DCD clear
	localparam reg_byte_t RR1_IDLE   = 8'h07;  // All sent with the residue code at 011

	// Bit positions inside registers
	localparam int DCD_IE_BIT  = 3;  // WR15 DCD ext/status enable
	localparam int EXT_IE_BIT  = 0;  // WR1 ext/status master enable
	localparam int MIE_BIT     = 3;  // WR9 master interrupt enable
	localparam int VIS_BIT     = 0;  // WR9 vector includes status
	localparam int STAT_HI_BIT = 4;  // WR9 status goes into bits 6:4
	localparam int RR0_DCD_BIT = 3;  // DCD position in RR0

	// Vector status codes in priority order
	localparam vec_stat_t VEC_STAT_A    = 3'b101;  // Channel A ext/status pending
	localparam vec_stat_t VEC_STAT_B    = 3'b001;  // Channel B ext/status pending
	localparam vec_stat_t VEC_STAT_NONE = 3'b011;  // Nothing pending

endpackage

// ==== rtl/scc_reg_index.sv ====
module scc_reg_index import scc_pkg::*; (
	input  logic       sysclk,
	input  logic       reset_hw,
	input  logic       cs,
	input  logic       we,
	input  reg_sel_t   rs,
	input  reg_byte_t  wdata,
	output reg_index_t rindex,
	output logic       wreg_a,
	output logic       wreg_b,
	output logic       ext_cmd_a,
	output logic       ext_cmd_b,
	output logic       full_reset,
	output logic       chan_reset_a,
	output logic       chan_reset_b,
	output logic       vec_wr,
	output logic       ctl_wr
);

	logic ctl_acc;   // Any control-port access this cycle
	logic wreg_any;  // Control write from either side
	logic at_wr0;    // Pointer is at register 0

	assign ctl_acc  = cs && !rs[RS_DATA_BIT];  // Data port never touches the pointer
	assign wreg_a   = ctl_acc && we && rs[RS_SIDE_A_BIT];
	assign wreg_b   = ctl_acc && we && !rs[RS_SIDE_A_BIT];
	assign wreg_any = wreg_a || wreg_b;
	assign at_wr0   = (rindex == '0);

	// The pointer is loaded by a WR0 write and falls back to 0 after any other control access
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex <= '0;
		end else if (ctl_acc) begin
			if (we && at_wr0) begin
				rindex <= {wdata[5:3] == CMD_POINT_HIGH, wdata[2:0]};  // Point high adds 8
			end else begin
				rindex <= '0;  // Reads and writes at non-zero index both return it
			end
		end
	end

	assign ext_cmd_a = wreg_a && at_wr0 && (wdata[5:3] == CMD_RESET_EXT);  // Per side command
	assign ext_cmd_b = wreg_b && at_wr0 && (wdata[5:3] == CMD_RESET_EXT);

	// WR2 and WR9 are shared, so the side does not matter
	assign vec_wr = wreg_any && (rindex == WR_VECTOR);
	assign ctl_wr = wreg_any && (rindex == WR_MASTER_CTRL);

	// Single-cycle reset pulses from the WR9 command bits
	assign full_reset   = (ctl_wr && (wdata[7:6] == RST_FULL)) || reset_hw;
	assign chan_reset_a = (ctl_wr && (wdata[7:6] == RST_CHAN_A)) || full_reset;
	assign chan_reset_b = (ctl_wr && (wdata[7:6] == RST_CHAN_B)) || full_reset;

endmodule

// ==== rtl/scc_channel.sv ====
module scc_channel import scc_pkg::*; (
	input  logic       sysclk,
	input  logic       reset_hw,
	input  logic       full_reset,
	input  logic       chan_reset,
	input  logic       wreg,
	input  logic       ext_cmd,
	input  reg_index_t rindex,
	input  reg_byte_t  wdata,
	input  logic       dcd,
	output reg_byte_t  wr12,
	output reg_byte_t  wr13,
	output reg_byte_t  rr15,
	output logic       rr0_dcd,
	output logic       ext_pend
);

	reg_byte_t wr1;         // Interrupt enables
	reg_byte_t wr15;        // Ext/status source enables
	logic      latch_open;  // Ext/status latch is following its sources
	logic      dcd_latch;   // DCD value frozen when the latch closed
	logic      dcd_change;  // Enabled DCD source differs from the latch
	logic      do_latch;    // Latch closes on this edge

	// WR1 keeps bits 5 and 2 across a channel reset
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			wr1 <= '0;
		end else if (chan_reset) begin
			wr1 <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00};
		end else if (wreg && rindex == WR_IRQ_ENABLE) begin
			wr1 <= wdata;
		end
	end

	// Time constant registers survive every soft reset
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			wr12 <= '0;
			wr13 <= '0;
		end else if (wreg) begin
			if (rindex == WR_TIME_LO) begin
				wr12 <= wdata;
			end
			if (rindex == WR_TIME_HI) begin
				wr13 <= wdata;
			end
		end
	end

	// WR15 goes back to its default only on a full reset, not on a channel reset
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			wr15 <= WR15_RESET;
		end else if (full_reset) begin
			wr15 <= WR15_RESET;
		end else if (wreg && rindex == WR_EXT_ENABLE) begin
			wr15 <= wdata;
		end
	end

	assign rr15 = wr15 & RR15_MASK;  // Unimplemented enables read back as 0

	// Only DCD feeds the latch here since CTS and the others are not modelled
	assign dcd_change = (dcd != dcd_latch) && wr15[DCD_IE_BIT];
	assign do_latch   = latch_open && dcd_change;

	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
		end else if (full_reset) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
		end else if (ext_cmd) begin
			latch_open <= 1'b1;  // Reset ext/status reopens the latch
		end else if (do_latch) begin
			latch_open <= 1'b0;
			dcd_latch  <= dcd;   // Freeze the value that caused the change
		end
	end

	// Pending bit sets with the latch closing when WR1 allows it
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			ext_pend <= 1'b0;
		end else if (full_reset || ext_cmd) begin
			ext_pend <= 1'b0;
		end else if (do_latch && wr1[EXT_IE_BIT]) begin
			ext_pend <= 1'b1;
		end
	end

	assign rr0_dcd = wr15[DCD_IE_BIT] ? dcd_latch : dcd;  // Live pin when the source is off

endmodule

// ==== rtl/scc_irq_ctrl.sv ====
module scc_irq_ctrl import scc_pkg::*; (
	input  logic      sysclk,
	input  logic      reset_hw,
	input  logic      vec_wr,
	input  logic      ctl_wr,
	input  reg_byte_t wdata,
	input  logic      ext_pend_a,
	input  logic      ext_pend_b,
	output reg_byte_t wr2,
	output reg_byte_t rr2_b,
	output reg_byte_t rr3,
	output logic      irq_n
);

	logic [5:0] wr9;       // Low bits of WR9, the top two are reset commands
	vec_stat_t  vec_stat;  // Status code of the highest pending source
	logic       any_pend;  // Some ext/status source is pending

	// Shared vector register, untouched by soft resets
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			wr2 <= '0;
		end else if (vec_wr) begin
			wr2 <= wdata;
		end
	end

	// Master control bits, also kept across soft resets
	always_ff @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			wr9 <= '0;
		end else if (ctl_wr) begin
			wr9 <= wdata[5:0];
		end
	end

	// Channel A wins over channel B
	always_comb begin
		if (ext_pend_a) begin
			vec_stat = VEC_STAT_A;
		end else if (ext_pend_b) begin
			vec_stat = VEC_STAT_B;
		end else begin
			vec_stat = VEC_STAT_NONE;
		end
	end

	// Status high puts the code into bits 6:4 in reversed order
	always_comb begin
		if (!wr9[VIS_BIT]) begin
			rr2_b = wr2;  // Plain vector when status is not included
		end else if (wr9[STAT_HI_BIT]) begin
			rr2_b = {wr2[7], vec_stat[0], vec_stat[1], vec_stat[2], wr2[3:0]};
		end else begin
			rr2_b = {wr2[7:4], vec_stat, wr2[0]};
		end
	end

	// Rx and Tx pending bits are never set since the serial side is absent
	assign rr3 = {4'b0000, ext_pend_a, 2'b00, ext_pend_b};

	assign any_pend = ext_pend_a || ext_pend_b;
	assign irq_n    = !(wr9[MIE_BIT] && any_pend);  // Open-drain style, low when active

endmodule

// ==== rtl/scc_read_mux.sv ====
module scc_read_mux import scc_pkg::*; (
	input  reg_sel_t   rs,
	input  reg_index_t rindex,
	input  reg_byte_t  wr12_a,
	input  reg_byte_t  wr12_b,
	input  reg_byte_t  wr13_a,
	input  reg_byte_t  wr13_b,
	input  reg_byte_t  rr15_a,
	input  reg_byte_t  rr15_b,
	input  logic       rr0_dcd_a,
	input  logic       rr0_dcd_b,
	input  reg_byte_t  wr2,
	input  reg_byte_t  rr2_b,
	input  reg_byte_t  rr3,
	output reg_byte_t  rdata
);

	logic      side_a;    // Access is for channel A
	logic      sel_dcd;   // DCD bit of the selected channel
	reg_byte_t rr0_sel;   // RR0 of the selected channel
	reg_byte_t rr2_sel;   // WR2 on A, vector with status on B
	reg_byte_t rr3_sel;   // RR3 exists on channel A only
	reg_byte_t wr12_sel;  // Selected WR12
	reg_byte_t wr13_sel;  // Selected WR13
	reg_byte_t rr15_sel;  // Selected RR15

	assign side_a  = rs[RS_SIDE_A_BIT];
	assign sel_dcd = side_a ? rr0_dcd_a : rr0_dcd_b;

	// Fixed Tx status with DCD inserted
	always_comb begin
		rr0_sel              = RR0_IDLE;
		rr0_sel[RR0_DCD_BIT] = sel_dcd;
	end

	assign rr2_sel  = side_a ? wr2 : rr2_b;
	assign rr3_sel  = side_a ? rr3 : '0;
	assign wr12_sel = side_a ? wr12_a : wr12_b;
	assign wr13_sel = side_a ? wr13_a : wr13_b;
	assign rr15_sel = side_a ? rr15_a : rr15_b;

	// Pointer table with the aliases of the original part
	always_comb begin
		rdata = '0;  // Data port, index 8, RR10 and RR14 all read zero
		if (!rs[RS_DATA_BIT]) begin
			case (rindex)
				4'd0, 4'd4:               rdata = rr0_sel;
				4'd1, 4'd5:               rdata = RR1_IDLE;
				4'd2, 4'd6:               rdata = rr2_sel;
				4'd3, 4'd7:               rdata = rr3_sel;
				4'd9, WR_TIME_HI:         rdata = wr13_sel;  // Index 9 mirrors 13
				4'd11, WR_EXT_ENABLE:     rdata = rr15_sel;  // Index 11 mirrors 15
				WR_TIME_LO:               rdata = wr12_sel;
				default:                  rdata = '0;
			endcase
		end
	end

endmodule

// ==== rtl/scc_top.sv ====
module scc_top import scc_pkg::*; (
	input  logic      sysclk,
	input  logic      reset_hw,
	input  logic      cs,
	input  logic      we,
	input  reg_sel_t  rs,
	input  reg_byte_t wdata,
	output reg_byte_t rdata,
	output logic      irq_n,
	input  logic      dcd_a,
	input  logic      dcd_b
);

	reg_index_t rindex;        // Shared register pointer
	logic       wreg_a;        // Control write strobes per side
	logic       wreg_b;
	logic       ext_cmd_a;     // Reset ext/status commands per side
	logic       ext_cmd_b;
	logic       full_reset;    // WR9 full reset or hardware reset
	logic       chan_reset_a;  // Channel resets, full reset included
	logic       chan_reset_b;
	logic       vec_wr;        // WR2 write
	logic       ctl_wr;        // WR9 write
	reg_byte_t  wr12_a;
	reg_byte_t  wr12_b;
	reg_byte_t  wr13_a;
	reg_byte_t  wr13_b;
	reg_byte_t  rr15_a;
	reg_byte_t  rr15_b;
	logic       rr0_dcd_a;     // DCD bits as shown in RR0
	logic       rr0_dcd_b;
	logic       ext_pend_a;    // Ext/status interrupt pending per channel
	logic       ext_pend_b;
	reg_byte_t  wr2;
	reg_byte_t  rr2_b;
	reg_byte_t  rr3;

	scc_reg_index i_reg_index (
		.sysclk       (sysclk),
		.reset_hw     (reset_hw),
		.cs           (cs),
		.we           (we),
		.rs           (rs),
		.wdata        (wdata),
		.rindex       (rindex),
		.wreg_a       (wreg_a),
		.wreg_b       (wreg_b),
		.ext_cmd_a    (ext_cmd_a),
		.ext_cmd_b    (ext_cmd_b),
		.full_reset   (full_reset),
		.chan_reset_a (chan_reset_a),
		.chan_reset_b (chan_reset_b),
		.vec_wr       (vec_wr),
		.ctl_wr       (ctl_wr)
	);

	scc_channel ch_a (
		.sysclk     (sysclk),
		.reset_hw   (reset_hw),
		.full_reset (full_reset),
		.chan_reset (chan_reset_a),
		.wreg       (wreg_a),
		.ext_cmd    (ext_cmd_a),
		.rindex     (rindex),
		.wdata      (wdata),
		.dcd        (dcd_a),
		.wr12       (wr12_a),
		.wr13       (wr13_a),
		.rr15       (rr15_a),
		.rr0_dcd    (rr0_dcd_a),
		.ext_pend   (ext_pend_a)
	);

	scc_channel ch_b (
		.sysclk     (sysclk),
		.reset_hw   (reset_hw),
		.full_reset (full_reset),
		.chan_reset (chan_reset_b),
		.wreg       (wreg_b),
		.ext_cmd    (ext_cmd_b),
		.rindex     (rindex),
		.wdata      (wdata),
		.dcd        (dcd_b),
		.wr12       (wr12_b),
		.wr13       (wr13_b),
		.rr15       (rr15_b),
		.rr0_dcd    (rr0_dcd_b),
		.ext_pend   (ext_pend_b)
	);

	scc_irq_ctrl i_irq_ctrl (
		.sysclk     (sysclk),
		.reset_hw   (reset_hw),
		.vec_wr     (vec_wr),
		.ctl_wr     (ctl_wr),
		.wdata      (wdata),
		.ext_pend_a (ext_pend_a),
		.ext_pend_b (ext_pend_b),
		.wr2        (wr2),
		.rr2_b      (rr2_b),
		.rr3        (rr3),
		.irq_n      (irq_n)
	);

	scc_read_mux i_read_mux (
		.rs        (rs),
		.rindex    (rindex),
		.wr12_a    (wr12_a),
		.wr12_b    (wr12_b),
		.wr13_a    (wr13_a),
		.wr13_b    (wr13_b),
		.rr15_a    (rr15_a),
		.rr15_b    (rr15_b),
		.rr0_dcd_a (rr0_dcd_a),
		.rr0_dcd_b (rr0_dcd_b),
		.wr2       (wr2),
		.rr2_b     (rr2_b),
		.rr3       (rr3),
		.rdata     (rdata)
	);

endmodule

// ==== tb/scc_checker.sv ====
module scc_checker import scc_pkg::*; (
	input  logic      sysclk, reset_hw, cs, we,
	input  reg_sel_t  rs,
	input  reg_byte_t wdata, rdata,
	input  logic      irq_n, dcd_a, dcd_b,
	input  int        test_num,
	input  logic      test_done, all_done,
	output int        err_count
);

	reg_index_t      m_ptr;                     // Model of the register pointer
	logic [1:0][7:0] m_wr1, m_wr12, m_wr13, m_wr15;  // Index 1 is channel A, 0 is B
	reg_byte_t       m_wr2;                     // Shared vector
	logic [5:0]      m_wr9;                     // Low bits of the master control
	logic [1:0]      m_open, m_latch, m_pend;   // Ext/status latch state per channel
	logic [1:0]      dcd_in, wsel, chan_rst, ext_cmd;
	logic            ctl, full, exp_irq;
	reg_byte_t       exp_rd;
	int errors = 0, checks = 0, base = 0, tests_ok = 0, tests_bad = 0;

	assign err_count = errors;

	// Vector with status as the B side reads it
	function automatic reg_byte_t vector_expect();
		logic [2:0] code;
		reg_byte_t  v;
		code = m_pend[1] ? 3'b101 : (m_pend[0] ? 3'b001 : 3'b011);  // A outranks B
		v    = m_wr2;
		if (m_wr9[0] && m_wr9[4]) begin
			v[6] = code[0];  // Status high puts the code in reversed
			v[5] = code[1];
			v[4] = code[2];
		end else if (m_wr9[0]) begin
			v[3:1] = code;
		end
		return v;
	endfunction

	function automatic reg_byte_t read_expect();
		logic       s;
		logic [3:0] idx;
		logic       dcd_seen;
		s        = rs[0];
		idx      = (m_ptr[3:2] == 2'b01) ? {2'b00, m_ptr[1:0]} : m_ptr;  // 4 to 7 mirror 0 to 3
		dcd_seen = m_wr15[s][3] ? m_latch[s] : dcd_in[s];
		if (rs[1]) begin
			return 8'h00;  // Data registers never load
		end
		case (idx)
			4'd0:         return 8'h44 | {4'h0, dcd_seen, 3'b000};
			4'd1:         return 8'h07;
			4'd2:         return s ? m_wr2 : vector_expect();
			4'd3:         return s ? {4'h0, m_pend[1], 2'b00, m_pend[0]} : 8'h00;
			4'd9, 4'd13:  return m_wr13[s];
			4'd11, 4'd15: return m_wr15[s] & RR15_MASK;
			4'd12:        return m_wr12[s];
			default:      return 8'h00;
		endcase
	endfunction

	always @(posedge sysclk or posedge reset_hw) begin
		if (reset_hw) begin
			m_ptr   = '0;
			m_wr1   = '0;
			m_wr12  = '0;
			m_wr13  = '0;
			m_wr15  = {2{8'hF8}};
			m_wr2   = '0;
			m_wr9   = '0;
			m_open  = 2'b11;
			m_latch = 2'b00;
			m_pend  = 2'b00;
		end else begin
			dcd_in = {dcd_a, dcd_b};
			if (cs && !we) begin  // Read presented on this edge
				exp_rd = read_expect();
				checks = checks + 1;
				if (rdata !== exp_rd) begin
					errors = errors + 1;
					$display("FAILED rdata: rs %h index %h expected %h got %h", rs, m_ptr, exp_rd, rdata);
				end
			end
			exp_irq = !(m_wr9[3] && (m_pend != 2'b00));
			checks  = checks + 1;
			if (irq_n !== exp_irq) begin
				errors = errors + 1;
				$display("FAILED irq_n: expected %h got %h", exp_irq, irq_n);
			end
			ctl      = cs && !rs[1];
			wsel     = {2{ctl && we}} & {rs[0], !rs[0]};
			chan_rst = (wsel != 2'b00 && m_ptr == 4'd9) ? wdata[7:6] : 2'b00;  // 10 is A, 01 is B
			full     = (chan_rst == 2'b11);
			ext_cmd  = (m_ptr == 4'd0 && wdata[5:3] == 3'b010) ? wsel : 2'b00;
			for (int c = 0; c < 2; c++) begin
				if (full) begin
					m_open[c]  = 1'b1;
					m_latch[c] = 1'b0;
					m_pend[c]  = 1'b0;
				end else if (ext_cmd[c]) begin
					m_open[c] = 1'b1;  // Latch reopens, value kept
					m_pend[c] = 1'b0;
				end else if (m_open[c] && m_wr15[c][3] && dcd_in[c] != m_latch[c]) begin
					m_open[c]  = 1'b0;
					m_latch[c] = dcd_in[c];
					m_pend[c]  = m_pend[c] | m_wr1[c][0];
				end
				if (chan_rst[c]) begin
					m_wr1[c] = m_wr1[c] & 8'h24;  // Only bits 5 and 2 survive
				end else if (wsel[c] && m_ptr == 4'd1) begin
					m_wr1[c] = wdata;
				end
				if (wsel[c] && m_ptr == 4'd12) begin
					m_wr12[c] = wdata;
				end
				if (wsel[c] && m_ptr == 4'd13) begin
					m_wr13[c] = wdata;
				end
				if (full) begin
					m_wr15[c] = 8'hF8;
				end else if (wsel[c] && m_ptr == 4'd15) begin
					m_wr15[c] = wdata;
				end
			end
			if (wsel != 2'b00 && m_ptr == 4'd2) begin
				m_wr2 = wdata;
			end
			if (wsel != 2'b00 && m_ptr == 4'd9) begin
				m_wr9 = wdata[5:0];
			end
			if (ctl) begin
				m_ptr = (we && m_ptr == 4'd0) ? {wdata[5:3] == 3'b001, wdata[2:0]} : 4'd0;
			end
			if (test_done) begin
				$display("test %0d: %0d errors, %s", test_num, errors - base,
					(errors == base) ? "passed" : "failed");
				if (errors == base) begin
					tests_ok = tests_ok + 1;
				end else begin
					tests_bad = tests_bad + 1;
				end
				base = errors;
			end
			if (all_done) begin
				$display("tests passed %0d failed %0d, checks %0d errors %0d",
					tests_ok, tests_bad, checks, errors);
			end
		end
	end

endmodule

// ==== tb/scc_tb.sv ====
module scc_tb import scc_pkg::*; ();

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 8;
	localparam int RAND_ITER    = 60;  // Write/readback rounds
	localparam int PTR_ITER     = 30;  // Pointer return rounds
	localparam int EXT_ITER     = 12;  // DCD toggle rounds
	localparam int VEC_ITER     = 4;   // Vector rounds per status position
	// Upper estimate of bus cycles, one per access
	localparam int N_ACCESS = 20 + RAND_ITER * 4 + PTR_ITER * 10 + EXT_ITER * 20 + VEC_ITER * 40 + 40;
	localparam int WATCHDOG = (RESET_CYCLES + N_ACCESS * 3 + 100) * 2 * HALF_PERIOD;

	logic       sysclk, reset_hw, cs, we, dcd_a, dcd_b, irq_n;
	reg_sel_t   rs;
	reg_byte_t  wdata, rdata, r;
	reg_index_t idx;
	logic       side, cur;
	logic       test_done, all_done;
	int         test_num, err_count;
	integer     seed;

	always #(HALF_PERIOD) sysclk = !sysclk;

	scc_top i_dut (
		.sysclk   (sysclk),
		.reset_hw (reset_hw),
		.cs       (cs),
		.we       (we),
		.rs       (rs),
		.wdata    (wdata),
		.rdata    (rdata),
		.irq_n    (irq_n),
		.dcd_a    (dcd_a),
		.dcd_b    (dcd_b)
	);

	scc_checker i_checker (.*);

	function automatic reg_byte_t rand_byte();
		logic [31:0] v;
		v = $random(seed);
		return v[7:0];
	endfunction

	function automatic logic rand_bit();
		logic [31:0] v;
		v = $random(seed);
		return v[0];
	endfunction

	// One bus access, set up on the falling edge and taken on the rising edge
	task automatic access(input logic wr, input reg_sel_t sel, input reg_byte_t data);
		@(negedge sysclk);
		cs    = 1'b1;
		we    = wr;
		rs    = sel;
		wdata = data;
		@(posedge sysclk);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge sysclk);
			cs = 1'b0;
			@(posedge sysclk);
		end
	endtask

	// WR0 write that loads the pointer, point high for 8 and up
	task automatic point(input logic s, input reg_index_t i);
		if (i != 4'd0) begin
			access(1'b1, {1'b0, s}, {2'b00, (i[3] ? CMD_POINT_HIGH : 3'b000), i[2:0]});
		end
	endtask

	task automatic ctl_write(input logic s, input reg_index_t i, input reg_byte_t d);
		point(s, i);
		access(1'b1, {1'b0, s}, d);
	endtask

	task automatic ctl_read(input logic s, input reg_index_t i);
		point(s, i);
		access(1'b0, {1'b0, s}, rand_byte());
	endtask

	task automatic ext_reset(input logic s);
		access(1'b1, {1'b0, s}, {2'b00, CMD_RESET_EXT, 3'b000});
	endtask

	task automatic set_dcd(input logic s, input logic v);
		@(negedge sysclk);
		cs = 1'b0;
		if (s) begin
			dcd_a = v;
		end else begin
			dcd_b = v;
		end
		@(posedge sysclk);
	endtask

	// Toggle DCD so the latch closes, read the vector, then clear with dcd equal to the latch
	task automatic pend_and_clear(input logic s);
		cur = s ? dcd_a : dcd_b;
		set_dcd(s, !cur);
		ctl_read(1'b0, WR_VECTOR);
		ext_reset(s);
		ctl_read(1'b0, WR_VECTOR);
	endtask

	task automatic end_test();
		@(negedge sysclk);
		cs        = 1'b0;
		test_done = 1'b1;
		@(negedge sysclk);
		test_done = 1'b0;
		test_num  = test_num + 1;
	endtask

	initial begin
		seed      = 32'hb7e03862;
		sysclk    = 1'b0;
		reset_hw  = 1'b1;
		cs        = 1'b0;
		we        = 1'b0;
		rs        = '0;
		wdata     = '0;
		dcd_a     = 1'b0;
		dcd_b     = 1'b0;
		test_done = 1'b0;
		all_done  = 1'b0;
		test_num  = 1;
		repeat (RESET_CYCLES) @(posedge sysclk);
		@(negedge sysclk);
		reset_hw = 1'b0;

		// Reset values on both channels
		for (int s = 0; s < 2; s++) begin
			ctl_read(s[0], WR_EXT_ENABLE);
			ctl_read(s[0], WR_TIME_LO);
			ctl_read(s[0], WR_TIME_HI);
			ctl_read(s[0], 4'd0);
		end
		ctl_read(1'b0, WR_VECTOR);
		end_test();

		// Random write and readback with the aliases
		repeat (RAND_ITER) begin
			r    = rand_byte();
			side = r[0];
			case (r[2:1])
				2'd0:    idx = WR_VECTOR;
				2'd1:    idx = WR_TIME_LO;
				2'd2:    idx = WR_TIME_HI;
				default: idx = WR_EXT_ENABLE;
			endcase
			ctl_write(side, idx, rand_byte());
			if (r[3] && idx == WR_TIME_HI) begin
				idx = 4'd9;
			end
			if (r[3] && idx == WR_EXT_ENABLE) begin
				idx = 4'd11;
			end
			ctl_read((idx == WR_VECTOR) ? r[4] : side, idx);  // WR2 is shared
		end
		end_test();

		// Pointer return and data port reads
		repeat (PTR_ITER) begin
			r    = rand_byte();
			side = r[0];
			idx  = (r[7:4] == 4'd0) ? 4'd1 : r[7:4];
			if (r[1]) begin
				ctl_write(side, {3'b110, r[2]}, rand_byte());
			end else begin
				ctl_read(side, idx);
			end
			if (r[3]) begin
				access(1'b0, {1'b1, side}, rand_byte());
			end
			access(1'b0, {1'b0, r[5]}, rand_byte());  // Back at 0, so RR0
			point(side, idx);
			access(1'b0, {1'b1, side}, rand_byte());  // Pointer must survive this
			access(1'b0, {1'b0, side}, rand_byte());
		end
		end_test();

		// External/status interrupt on DCD
		for (int s = 0; s < 2; s++) begin
			ctl_write(s[0], WR_EXT_ENABLE, rand_byte() | 8'h08);
			ctl_write(s[0], WR_IRQ_ENABLE, 8'h01);
			ext_reset(s[0]);
		end
		ctl_write(1'b1, WR_MASTER_CTRL, 8'h08);  // MIE only
		repeat (EXT_ITER) begin
			r    = rand_byte();
			side = r[0];
			cur  = side ? dcd_a : dcd_b;
			idle(int'(r[3:1]));
			set_dcd(side, !cur);
			ctl_read(side, 4'd0);
			set_dcd(side, cur);       // Latched value must hold
			ctl_read(side, 4'd0);
			ctl_read(1'b1, 4'd3);
			set_dcd(side, !cur);
			ext_reset(side);
			ctl_read(1'b1, 4'd3);
		end
		end_test();

		// Vector with status, low and high positions
		for (int h = 0; h < 2; h++) begin
			ctl_write(1'b0, WR_MASTER_CTRL, {3'b000, h[0], 4'b1001});
			repeat (VEC_ITER) begin
				ctl_write(rand_bit(), WR_VECTOR, rand_byte());
				ctl_read(1'b0, WR_VECTOR);
				pend_and_clear(1'b1);
				pend_and_clear(1'b0);
			end
		end
		end_test();

		// Channel A reset, then full reset
		ctl_write(1'b1, WR_TIME_LO, rand_byte());
		ctl_write(1'b0, WR_TIME_LO, rand_byte());
		ctl_write(1'b1, WR_EXT_ENABLE, rand_byte() | 8'h08);
		ctl_write(1'b0, WR_EXT_ENABLE, rand_byte() | 8'h08);
		ctl_write(1'b1, WR_MASTER_CTRL, 8'h89);  // Reset A with MIE and VIS kept
		set_dcd(1'b1, !dcd_a);                  // A no longer flags pending
		ctl_read(1'b1, 4'd3);
		set_dcd(1'b0, !dcd_b);                  // B still does
		ctl_read(1'b1, 4'd3);
		for (int s = 0; s < 2; s++) begin
			ctl_read(s[0], WR_TIME_LO);
			ctl_read(s[0], WR_EXT_ENABLE);
		end
		ctl_write(1'b0, WR_MASTER_CTRL, 8'hC9);
		for (int s = 0; s < 2; s++) begin
			ctl_read(s[0], WR_EXT_ENABLE);
			ctl_read(s[0], WR_TIME_LO);
			ctl_read(s[0], WR_TIME_HI);
		end
		ctl_read(1'b1, WR_VECTOR);
		ctl_read(1'b1, 4'd3);
		end_test();

		@(negedge sysclk);
		all_done = 1'b1;
		@(posedge sysclk);
		#1;
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("Timeout: the tests did not finish within %0d time units", WATCHDOG);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== all.f ====
rtl/scc_pkg.sv
rtl/scc_reg_index.sv
rtl/scc_channel.sv
rtl/scc_irq_ctrl.sv
rtl/scc_read_mux.sv
rtl/scc_top.sv
tb/scc_checker.sv
tb/scc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -j 0 -f all.f --top-module scc_tb > build.log 2>&1 \
	&& ./obj_dir/Vscc_tb > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; } \
	|| echo "no failure reported in sim.log"
